/* vlog.f */
verilog/uop_pkg.sv
verilog/instr_decode.sv
verilog/ucode_rom.sv
verilog/ucode_seq.sv
verilog/uop_queue.sv
verilog/uop_frontend.sv
test/tb_clock.sv
test/uop_frontend_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run uop_frontend_tb, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module uop_frontend_tb -f vlog.f
	./obj_dir/Vuop_frontend_tb | tee $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* test/uop_frontend_tb.sv */
`timescale 1ns/1ns

module uop_frontend_tb;

    localparam int NUM_SIMPLE = 24;
    localparam int NUM_TRAP   = 4;
    localparam int NUM_MIXED  = 48;
    localparam int NUM_AFTER  = 6;
    localparam int NUM_INSTR  = NUM_SIMPLE + 2 * NUM_TRAP + NUM_MIXED + NUM_AFTER + 1;
    localparam int TIMEOUT    = 40 * NUM_INSTR + 200;

    logic          clk;
    logic          reset;
    logic          nuke;
    logic          instr_valid;
    logic [31:0]   instr_word;
    logic          instr_ready;
    logic          out_take = 1'b0;
    logic          out_valid;
    uop_pkg::uop_t out_uop;

    logic          take_level;
    logic          random_take;
    logic [31:0]   stim_rng = 32'd87499;
    logic [31:0]   take_rng = 32'd87499;
    uop_pkg::uop_t model [$];
    int            error_count = 0;
    int            checked_count = 0;
    int            cycle_count = 0;
    logic          reset_seen = 1'b0;
    logic          after_nuke = 1'b0;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    uop_frontend #(
        .QUEUE_DEPTH (4)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .nuke        (nuke),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .instr_ready (instr_ready),
        .out_take    (out_take),
        .out_valid   (out_valid),
        .out_uop     (out_uop)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic uop_pkg::operand_t reg_opnd(input logic [4:0] r);
        uop_pkg::operand_t o;
        o.optype = uop_pkg::OPT_REG;
        o.regnum = r;
        return o;
    endfunction

    function automatic uop_pkg::uop_t build_uop(
        input uop_pkg::uop_op_t  op,
        input uop_pkg::operand_t dst,
        input uop_pkg::operand_t src1,
        input uop_pkg::operand_t src2,
        input logic [11:0]       imm,
        input logic              eom
    );
        uop_pkg::uop_t u;
        u      = '0;
        u.op   = op;
        u.dst  = dst;
        u.src1 = src1;
        u.src2 = src2;
        u.imm  = imm;
        u.eom  = eom;
        return u;
    endfunction

    // Kind 0 simple or illegal, 1 MUL, 2 DIV, 3 anything
    function automatic logic [31:0] random_word(input logic [31:0] r, input int kind);
        logic [3:0] op;
        case (kind)
            0: op = (r[31:29] < 3'd6) ? {2'b00, r[29:28]} : {1'b1, r[30:28]};
            1: op = uop_pkg::OP_MUL;
            2: op = uop_pkg::OP_DIV;
            default: op = (r[31:29] < 3'd6) ? {1'b0, r[31:29]} : {1'b1, r[30:28]};
        endcase
        return {op, r[27:0]};
    endfunction

    // Expected uops of one accepted word with trap operands filled in
    task automatic add_expected(input logic [31:0] w);
        uop_pkg::operand_t d;
        uop_pkg::operand_t s1;
        uop_pkg::operand_t s2;
        uop_pkg::operand_t imm_opnd;
        uop_pkg::operand_t tmp0;
        uop_pkg::operand_t tmp1;
        d               = reg_opnd(w[27:23]);
        s1              = reg_opnd(w[22:18]);
        s2              = reg_opnd(w[17:13]);
        imm_opnd.optype = uop_pkg::OPT_IMM;
        imm_opnd.regnum = 5'd0;
        tmp0            = reg_opnd(uop_pkg::REG_TMP0);
        tmp1            = reg_opnd(uop_pkg::REG_TMP1);
        case (uop_pkg::instr_op_t'(w[31:28]))
            uop_pkg::OP_ADD: model.push_back(build_uop(uop_pkg::U_ADD, d, s1, s2, 12'd0, 1'b1));
            uop_pkg::OP_SUB: model.push_back(build_uop(uop_pkg::U_SUB, d, s1, s2, 12'd0, 1'b1));
            uop_pkg::OP_AND: model.push_back(build_uop(uop_pkg::U_AND, d, s1, s2, 12'd0, 1'b1));
            uop_pkg::OP_ADDI: begin
                model.push_back(build_uop(uop_pkg::U_ADD, d, s1, imm_opnd, w[11:0], 1'b1));
            end
            uop_pkg::OP_MUL: begin
                model.push_back(build_uop(uop_pkg::U_ADD, tmp0, s1, imm_opnd, 12'd0, 1'b0));
                model.push_back(build_uop(uop_pkg::U_ADD, tmp1, s2, imm_opnd, 12'd0, 1'b0));
                model.push_back(build_uop(uop_pkg::U_MULSTEP, d, tmp0, tmp1, 12'd0, 1'b1));
            end
            uop_pkg::OP_DIV: begin
                model.push_back(build_uop(uop_pkg::U_SUB, tmp0, s1, s2, 12'd0, 1'b0));
                model.push_back(build_uop(uop_pkg::U_DIVSTEP, d, tmp0, s2, 12'd0, 1'b1));
            end
            default: begin
                model.push_back(build_uop(uop_pkg::U_BREAK, reg_opnd(5'd0), reg_opnd(5'd0),
                                          reg_opnd(5'd0), 12'd0, 1'b1));
            end
        endcase
    endtask

    task automatic issue(input int kind);
        stim_rng = xorshift(stim_rng);
        instr_valid <= 1'b1;
        instr_word  <= random_word(stim_rng, kind);
        @(posedge clk);
        while (!instr_ready) begin
            @(posedge clk);
        end
        instr_valid <= 1'b0;
    endtask

    task automatic drain();
        do begin
            @(negedge clk);
        end while (model.size() != 0);
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        take_rng = xorshift(take_rng);
        out_take <= random_take ? take_rng[7] : take_level;
    end

    // Checks use the values from before the edge
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("%0d uops checked, %0d errors", checked_count, error_count);
            $display("test failed");
            $finish;
        end else if (reset) begin
            reset_seen = 1'b1;
        end else if (nuke) begin
            model.delete();
            after_nuke = 1'b1;
        end else begin
            if (reset_seen || after_nuke) begin
                assert (!out_valid) else begin
                    $display("CHECK FAILED out_valid got %h expected 0", out_valid);
                    error_count++;
                end
                assert (instr_ready) else begin
                    $display("CHECK FAILED instr_ready got %h expected 1", instr_ready);
                    error_count++;
                end
                reset_seen = 1'b0;
                after_nuke = 1'b0;
            end
            if (out_valid && out_take) begin
                if (model.size() == 0) begin
                    $display("A uop came out while none was expected");
                    error_count++;
                end else begin
                    assert (out_uop === model[0]) else begin
                        $display("CHECK FAILED out_uop got %h expected %h", out_uop, model[0]);
                        error_count++;
                    end
                    void'(model.pop_front());
                    checked_count++;
                end
            end
            // A stalled front end still holds an accepted word
            assert (instr_ready || model.size() != 0) else begin
                $display("A held word was lost while instr_ready was low");
                error_count++;
            end
            if (instr_valid && instr_ready) begin
                add_expected(instr_word);
            end
        end
    end

    initial begin
        nuke        <= 1'b0;
        instr_valid <= 1'b0;
        instr_word  <= '0;
        take_level  <= 1'b1;
        random_take <= 1'b0;
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        repeat (NUM_SIMPLE) issue(0);
        drain();
        repeat (NUM_TRAP) issue(1);
        drain();
        repeat (NUM_TRAP) issue(2);
        drain();
        // Random take lets the queue fill and stall the producer
        random_take <= 1'b1;
        repeat (NUM_MIXED) issue(3);
        drain();
        random_take <= 1'b0;
        take_level  <= 1'b0;
        issue(1);
        do begin
            @(posedge clk);
        end while (!out_valid);
        // MUL only partly enqueued here
        nuke <= 1'b1;
        @(posedge clk);
        nuke       <= 1'b0;
        take_level <= 1'b1;
        repeat (NUM_AFTER) issue(3);
        drain();
        repeat (10) @(posedge clk);
        $display("%0d uops checked, %0d errors", checked_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held over the first 10 rising edges
    initial begin
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* verilog/uop_frontend.sv */
`timescale 1ns/1ns

module uop_frontend #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          nuke,
    input  logic          instr_valid,
    input  logic [31:0]   instr_word,
    output logic          instr_ready,
    input  logic          out_take,
    output logic          out_valid,
    output uop_pkg::uop_t out_uop
);

    logic          de_valid;
    uop_pkg::uop_t de_uop;
    logic          seq_ready;
    logic          seq_valid;
    uop_pkg::uop_t seq_uop;
    logic          q_ready;

    instr_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .nuke        (nuke),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .instr_ready (instr_ready),
        .seq_ready   (seq_ready),
        .de_valid    (de_valid),
        .de_uop      (de_uop)
    );

    ucode_seq u_seq (
        .clk       (clk),
        .reset     (reset),
        .nuke      (nuke),
        .de_valid  (de_valid),
        .de_uop    (de_uop),
        .seq_ready (seq_ready),
        .q_ready   (q_ready),
        .seq_valid (seq_valid),
        .seq_uop   (seq_uop)
    );

    // Stands in for rename
    uop_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk       (clk),
        .reset     (reset),
        .nuke      (nuke),
        .seq_valid (seq_valid),
        .seq_uop   (seq_uop),
        .q_ready   (q_ready),
        .out_take  (out_take),
        .out_valid (out_valid),
        .out_uop   (out_uop)
    );

endmodule

/* verilog/uop_queue.sv */
`timescale 1ns/1ns

module uop_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          nuke,
    input  logic          seq_valid,
    input  uop_pkg::uop_t seq_uop,
    output logic          q_ready,
    input  logic          out_take,
    output logic          out_valid,
    output uop_pkg::uop_t out_uop
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    uop_pkg::uop_t mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic push;
    logic pop;

    // Depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign q_ready   = (count != CNT_W'(QUEUE_DEPTH));
    assign out_valid = (count != '0);
    assign out_uop   = mem[rd_ptr];
    assign push      = seq_valid && q_ready;
    assign pop       = out_take && out_valid;

    always_ff @(posedge clk) begin
        if (reset || nuke) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= seq_uop;
        end
    end

endmodule

/* verilog/ucode_seq.sv */
`timescale 1ns/1ns

module ucode_seq (
    input  logic          clk,
    input  logic          reset,
    input  logic          nuke,
    input  logic          de_valid,
    input  uop_pkg::uop_t de_uop,
    output logic          seq_ready,
    input  logic          q_ready,
    output logic          seq_valid,
    output uop_pkg::uop_t seq_uop
);

    typedef enum logic {
        IDLE,
        FETCH
    } seq_state_t;

    seq_state_t state;
    logic [$clog2(uop_pkg::ROM_ROWS)-1:0] upc;
    uop_pkg::uop_t trapped_uop;
    uop_pkg::uop_t rom_uop;
    uop_pkg::uop_t sub_uop;
    logic trap_now;
    logic enq;

    // Trap operand takes the trapped instruction's operand and its type
    function automatic uop_pkg::operand_t subst(
        input uop_pkg::operand_t opnd,
        input uop_pkg::uop_t     trap
    );
        case (opnd.optype)
            uop_pkg::OPT_TRAP_SRC1: return trap.src1;
            uop_pkg::OPT_TRAP_SRC2: return trap.src2;
            uop_pkg::OPT_TRAP_DST:  return trap.dst;
            default:                return opnd;
        endcase
    endfunction

    ucode_rom u_rom (
        .addr    (upc),
        .rom_uop (rom_uop)
    );

    assign trap_now  = (state == IDLE) && de_valid && q_ready && de_uop.trap_to_ucode;
    assign seq_ready = (state == IDLE) && q_ready;
    assign seq_valid = ((state == IDLE) && de_valid && !de_uop.trap_to_ucode) ||
                       (state == FETCH);
    assign enq       = seq_valid && q_ready;

    always_comb begin
        sub_uop      = rom_uop;
        sub_uop.dst  = subst(rom_uop.dst, trapped_uop);
        sub_uop.src1 = subst(rom_uop.src1, trapped_uop);
        sub_uop.src2 = subst(rom_uop.src2, trapped_uop);
    end

    assign seq_uop = (state == FETCH) ? sub_uop : de_uop;

    always_ff @(posedge clk) begin
        if (reset || nuke) begin
            state <= IDLE;
            upc   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (trap_now) begin
                        state <= FETCH;
                        upc   <= de_uop.rom_addr;
                    end
                end
                FETCH: begin
                    if (enq) begin
                        upc <= upc + 1'b1;
                        // Done once the last uop is in the queue
                        if (seq_uop.eom) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (trap_now) begin
            trapped_uop <= de_uop;
        end
    end

endmodule

/* verilog/ucode_rom.sv */
`timescale 1ns/1ns

module ucode_rom (
    input  logic [2:0]    addr,
    output uop_pkg::uop_t rom_uop
);

    function automatic uop_pkg::uop_t make_uop(
        input uop_pkg::uop_op_t  op,
        input uop_pkg::operand_t dst,
        input uop_pkg::operand_t src1,
        input uop_pkg::operand_t src2,
        input logic              eom
    );
        uop_pkg::uop_t u;
        u      = '0;
        u.op   = op;
        u.dst  = dst;
        u.src1 = src1;
        u.src2 = src2;
        u.eom  = eom;
        return u;
    endfunction

    localparam uop_pkg::operand_t TMP0  = '{optype: uop_pkg::OPT_REG, regnum: uop_pkg::REG_TMP0};
    localparam uop_pkg::operand_t TMP1  = '{optype: uop_pkg::OPT_REG, regnum: uop_pkg::REG_TMP1};
    localparam uop_pkg::operand_t TSRC1 = '{optype: uop_pkg::OPT_TRAP_SRC1, regnum: 5'd0};
    localparam uop_pkg::operand_t TSRC2 = '{optype: uop_pkg::OPT_TRAP_SRC2, regnum: 5'd0};
    localparam uop_pkg::operand_t TDST  = '{optype: uop_pkg::OPT_TRAP_DST, regnum: 5'd0};
    localparam uop_pkg::operand_t IMM0  = '{optype: uop_pkg::OPT_IMM, regnum: 5'd0};
    localparam uop_pkg::operand_t NONE  = '{optype: uop_pkg::OPT_REG, regnum: 5'd0};

    always_comb begin
        case (addr)
            // MUL sequence
            3'd0: rom_uop = make_uop(uop_pkg::U_ADD, TMP0, TSRC1, IMM0, 1'b0);
            3'd1: rom_uop = make_uop(uop_pkg::U_ADD, TMP1, TSRC2, IMM0, 1'b0);
            3'd2: rom_uop = make_uop(uop_pkg::U_MULSTEP, TDST, TMP0, TMP1, 1'b1);
            // DIV sequence
            3'd4: rom_uop = make_uop(uop_pkg::U_SUB, TMP0, TSRC1, TSRC2, 1'b0);
            3'd5: rom_uop = make_uop(uop_pkg::U_DIVSTEP, TDST, TMP0, TSRC2, 1'b1);
            // Unused rows end the sequence
            default: rom_uop = make_uop(uop_pkg::U_BREAK, NONE, NONE, NONE, 1'b1);
        endcase
    end

endmodule

/* verilog/instr_decode.sv */
`timescale 1ns/1ns

module instr_decode (
    input  logic          clk,
    input  logic          reset,
    input  logic          nuke,
    input  logic          instr_valid,
    input  logic [31:0]   instr_word,
    output logic          instr_ready,
    input  logic          seq_ready,
    output logic          de_valid,
    output uop_pkg::uop_t de_uop
);

    logic [31:0] word_q;

    // Register is free when empty or being consumed this cycle
    assign instr_ready = !de_valid || seq_ready;

    always_ff @(posedge clk) begin
        if (reset || nuke) begin
            de_valid <= 1'b0;
        end else if (instr_ready) begin
            de_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid && instr_ready) begin
            word_q <= instr_word;
        end
    end

    always_comb begin
        de_uop      = '0;
        de_uop.dst  = '{optype: uop_pkg::OPT_REG, regnum: word_q[27:23]};
        de_uop.src1 = '{optype: uop_pkg::OPT_REG, regnum: word_q[22:18]};
        de_uop.src2 = '{optype: uop_pkg::OPT_REG, regnum: word_q[17:13]};
        case (uop_pkg::instr_op_t'(word_q[31:28]))
            uop_pkg::OP_ADD: begin
                de_uop.op  = uop_pkg::U_ADD;
                de_uop.eom = 1'b1;
            end
            uop_pkg::OP_SUB: begin
                de_uop.op  = uop_pkg::U_SUB;
                de_uop.eom = 1'b1;
            end
            uop_pkg::OP_AND: begin
                de_uop.op  = uop_pkg::U_AND;
                de_uop.eom = 1'b1;
            end
            uop_pkg::OP_ADDI: begin
                de_uop.op   = uop_pkg::U_ADD;
                de_uop.src2 = '{optype: uop_pkg::OPT_IMM, regnum: 5'd0};
                de_uop.imm  = word_q[11:0];
                de_uop.eom  = 1'b1;
            end
            // Complex ops go to the microcode ROM
            uop_pkg::OP_MUL: begin
                de_uop.op            = uop_pkg::U_MULSTEP;
                de_uop.trap_to_ucode = 1'b1;
                de_uop.rom_addr      = uop_pkg::ROM_ENT_MUL;
            end
            uop_pkg::OP_DIV: begin
                de_uop.op            = uop_pkg::U_DIVSTEP;
                de_uop.trap_to_ucode = 1'b1;
                de_uop.rom_addr      = uop_pkg::ROM_ENT_DIV;
            end
            default: begin
                de_uop     = '0;
                de_uop.op  = uop_pkg::U_BREAK;
                de_uop.eom = 1'b1;
            end
        endcase
    end

endmodule

/* verilog/uop_pkg.sv */
package uop_pkg;

    // Instruction opcode in bits 31:28, remaining codes are illegal
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_ADDI = 4'd3,
        OP_MUL  = 4'd4,
        OP_DIV  = 4'd5
    } instr_op_t;

    typedef enum logic [2:0] {
        U_ADD     = 3'd0,
        U_SUB     = 3'd1,
        U_AND     = 3'd2,
        U_MULSTEP = 3'd3,
        U_DIVSTEP = 3'd4,
        U_BREAK   = 3'd5
    } uop_op_t;

    // Trap types are only found in microcode ROM rows
    typedef enum logic [2:0] {
        OPT_REG       = 3'd0,
        OPT_IMM       = 3'd1,
        OPT_TRAP_SRC1 = 3'd2,
        OPT_TRAP_SRC2 = 3'd3,
        OPT_TRAP_DST  = 3'd4
    } optype_t;

    typedef struct packed {
        optype_t    optype;
        logic [4:0] regnum;
    } operand_t;

    typedef struct packed {
        uop_op_t    op;
        operand_t   dst;
        operand_t   src1;
        operand_t   src2;
        logic [11:0] imm;
        logic       eom;
        logic       trap_to_ucode;
        logic [2:0] rom_addr;
    } uop_t;

    localparam int ROM_ROWS = 8;

    // Microcode entry points
    localparam logic [2:0] ROM_ENT_MUL = 3'd0;
    localparam logic [2:0] ROM_ENT_DIV = 3'd4;

    // Scratch registers, reserved for microcode
    localparam logic [4:0] REG_TMP0 = 5'd30;
    localparam logic [4:0] REG_TMP1 = 5'd31;

endpackage
